/* ir_lcd_pkg.sv */
package ir_lcd_pkg;

	typedef logic [7:0] ir_code_t;   // NEC command byte
	typedef logic [7:0] lcd_char_t;  // ascii char or lcd command
	typedef logic [6:0] seg_t;       // g,f,e,d,c,b,a, active low

	// shifted in from the top, so the first received bit ends up in addr[0]
	typedef struct packed {
		ir_code_t cmd_n;
		ir_code_t cmd;
		ir_code_t addr_n;
		ir_code_t addr;
	} nec_frame_t;

	typedef struct packed {
		logic      rs;    // 0 command, 1 data
		logic      rw;    // write only
		logic      en;
		lcd_char_t data;
	} lcd_bus_t;

	typedef enum logic [2:0] {
		nec_idle,
		nec_lead_mark,
		nec_lead_space,
		nec_bit_mark,
		nec_bit_space
	} nec_state_t;

	typedef enum logic [2:0] {
		lcd_off,
		lcd_init_cmd,
		lcd_init_wait,
		lcd_idle,
		lcd_write_addr,
		lcd_write_char,
		lcd_pulse,
		lcd_hold
	} lcd_state_t;

	localparam lcd_char_t lcd_func_set  = 8'h38;  // 8 bit, 2 lines, 5x8
	localparam lcd_char_t lcd_disp_on   = 8'h0C;  // display on, no cursor
	localparam lcd_char_t lcd_clear     = 8'h01;
	localparam lcd_char_t lcd_entry     = 8'h06;  // increment, no shift
	localparam lcd_char_t lcd_home_addr = 8'h80;  // ddram address 0

endpackage

/* nec_ir_decoder.sv */
`timescale 1ns/10ps

module nec_ir_decoder import ir_lcd_pkg::*; #(
	parameter int unit_cycles = 28125
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     irda_rxd,
	output ir_code_t code,
	output logic     code_valid
);

	localparam int cw = $clog2(unit_cycles * 32);
	localparam logic [cw-1:0] cnt_max = '1;

	logic [1:0]    rx_sync;
	logic          rx_d;
	logic          fall;
	logic          rise;
	logic [cw-1:0] cnt;
	logic          too_long;
	logic          bit_val;
	logic [4:0]    bit_cnt;
	nec_state_t    state;
	nec_frame_t    frame;
	nec_frame_t    frame_next;

	// accepted length window of a nominal duration, +-50 %
	function automatic logic in_win(input logic [cw-1:0] len, input int units);
		return (len >= units * unit_cycles / 2) && (len <= units * unit_cycles * 3 / 2);
	endfunction

	// longest legal length of the current mark or space
	function automatic int max_len(input nec_state_t st);
		case (st)
			nec_lead_mark:  return 24 * unit_cycles;
			nec_lead_space: return 12 * unit_cycles;
			nec_bit_mark:   return 3 * unit_cycles / 2;
			nec_bit_space:  return 9 * unit_cycles / 2;
			default:        return int'(cnt_max);
		endcase
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_sync <= 2'b11;  // line idles high
			rx_d    <= 1'b1;
		end else begin
			rx_sync <= {rx_sync[0], irda_rxd};
			rx_d    <= rx_sync[1];
		end
	end

	assign fall = rx_d & ~rx_sync[1];  // mark starts
	assign rise = ~rx_d & rx_sync[1];  // mark ends

	// cycles since the last edge, saturating
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (fall || rise) begin
			cnt <= '0;
		end else if (cnt != cnt_max) begin
			cnt <= cnt + 1'b1;
		end
	end

	assign too_long   = (state != nec_idle) && (cnt > max_len(state));
	assign bit_val    = !in_win(cnt, 1);  // long space is a one
	assign frame_next = {bit_val, frame[31:1]};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= nec_idle;
			bit_cnt    <= '0;
			code       <= '0;
			code_valid <= 1'b0;
		end else begin
			code_valid <= 1'b0;
			case (state)
				nec_idle: begin
					if (fall) state <= nec_lead_mark;
				end
				nec_lead_mark: begin
					if (too_long) state <= nec_idle;
					else if (rise) state <= in_win(cnt, 16) ? nec_lead_space : nec_idle;
				end
				nec_lead_space: begin
					if (too_long) begin
						state <= nec_idle;
					end else if (fall) begin
						// a 4 unit space is the repeat code, dropped here
						if (in_win(cnt, 8) && !in_win(cnt, 4)) begin
							state   <= nec_bit_mark;
							bit_cnt <= '0;
						end else begin
							state <= nec_idle;
						end
					end
				end
				nec_bit_mark: begin
					if (too_long) state <= nec_idle;
					else if (rise) state <= in_win(cnt, 1) ? nec_bit_space : nec_idle;
				end
				nec_bit_space: begin
					if (too_long) begin
						state <= nec_idle;  // truncated frame
					end else if (fall) begin
						if (in_win(cnt, 1) || in_win(cnt, 3)) begin
							frame   <= frame_next;
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == 5'd31) begin
								// this fall opens the stop mark
								state <= nec_idle;
								if (frame_next.cmd_n == ~frame_next.cmd) begin
									code       <= frame_next.cmd;
									code_valid <= 1'b1;
								end
							end else begin
								state <= nec_bit_mark;
							end
						end else begin
							state <= nec_idle;
						end
					end
				end
				default: state <= nec_idle;
			endcase
		end
	end

	a_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
		code_valid |=> !code_valid);

	a_idle_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
		(state == nec_idle && !fall && !rise) |=> cnt != '0);

endmodule

/* key_to_ascii.sv */
`timescale 1ns/10ps

module key_to_ascii import ir_lcd_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  ir_code_t  code,
	input  logic      code_valid,
	output lcd_char_t char_data,
	output logic      char_valid
);

	function automatic lcd_char_t map_key(input ir_code_t key);
		case (key)
			8'h00, 8'h01, 8'h02, 8'h03, 8'h04,
			8'h05, 8'h06, 8'h07, 8'h08, 8'h09:
				return 8'h30 + key;  // digits
			8'h0F:   return 8'h41;  // 'A'
			8'h13:   return 8'h42;  // 'B'
			8'h10:   return 8'h43;  // 'C'
			default: return 8'h30;  // unknown key shows '0'
		endcase
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			char_data <= 8'h30;
		end else if (code_valid) begin
			char_data <= map_key(code);
		end
	end

	// strobe leaves with the character
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			char_valid <= 1'b0;
		end else begin
			char_valid <= code_valid;
		end
	end

endmodule

/* lcd_writer.sv */
`timescale 1ns/10ps

module lcd_writer import ir_lcd_pkg::*; #(
	parameter int en_cycles   = 25,
	parameter int wait_cycles = 2500
) (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      power_req,
	input  lcd_char_t char_data,
	input  logic      char_valid,
	output lcd_bus_t  lcd,
	output logic      lcd_out_on
);

	localparam int tmax = (en_cycles > wait_cycles) ? en_cycles : wait_cycles;
	localparam int tw   = $clog2(tmax + 1);

	logic [1:0]    pw_sync;
	logic [1:0]    idx;        // init command index
	logic [tw-1:0] tcnt;       // shared setup, enable and wait timer
	lcd_state_t    state;
	lcd_state_t    ret_state;  // where a transfer returns to
	logic          pend_valid;
	lcd_char_t     pend_char;
	lcd_char_t     cur_char;

	function automatic lcd_char_t init_byte(input logic [1:0] i);
		case (i)
			2'd0:    return lcd_func_set;
			2'd1:    return lcd_disp_on;
			2'd2:    return lcd_clear;
			default: return lcd_entry;
		endcase
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pw_sync <= 2'b00;
		end else begin
			pw_sync <= {pw_sync[0], power_req};
		end
	end

	assign lcd_out_on = pw_sync[1];

	// waiting character and the one being written
	always_ff @(posedge clk) begin
		if (char_valid) pend_char <= char_data;
		if (state == lcd_idle && pend_valid) cur_char <= pend_char;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= lcd_off;
			ret_state  <= lcd_idle;
			idx        <= '0;
			tcnt       <= '0;
			pend_valid <= 1'b0;
			lcd        <= '0;
		end else if (!pw_sync[0]) begin
			// power falls on this edge, en drops with it
			state      <= lcd_off;
			tcnt       <= '0;
			pend_valid <= 1'b0;
			lcd.en     <= 1'b0;
		end else begin
			if (char_valid) pend_valid <= 1'b1;  // latest key wins
			case (state)
				lcd_off: begin
					if (lcd_out_on) begin
						idx   <= '0;
						state <= lcd_init_cmd;
					end
				end
				lcd_init_cmd: begin
					lcd.data  <= init_byte(idx);
					lcd.rs    <= 1'b0;
					ret_state <= lcd_init_wait;
					tcnt      <= '0;
					state     <= lcd_pulse;
				end
				lcd_init_wait: begin
					if (idx == 2'd3) begin
						state <= lcd_idle;
					end else begin
						idx   <= idx + 1'b1;
						state <= lcd_init_cmd;
					end
				end
				lcd_idle: begin
					if (pend_valid) begin
						if (!char_valid) pend_valid <= 1'b0;
						state <= lcd_write_addr;
					end
				end
				lcd_write_addr: begin
					lcd.data  <= lcd_home_addr;
					lcd.rs    <= 1'b0;
					ret_state <= lcd_write_char;
					tcnt      <= '0;
					state     <= lcd_pulse;
				end
				lcd_write_char: begin
					lcd.data  <= cur_char;
					lcd.rs    <= 1'b1;
					ret_state <= lcd_idle;
					tcnt      <= '0;
					state     <= lcd_pulse;
				end
				lcd_pulse: begin
					// first cycle here is the setup cycle
					tcnt <= tcnt + 1'b1;
					if (tcnt == '0) begin
						lcd.en <= 1'b1;
					end else if (tcnt == tw'(en_cycles)) begin
						lcd.en <= 1'b0;
						tcnt   <= '0;
						state  <= lcd_hold;
					end
				end
				lcd_hold: begin
					if (tcnt == tw'(wait_cycles - 1)) begin
						tcnt  <= '0;
						state <= ret_state;
					end else begin
						tcnt <= tcnt + 1'b1;
					end
				end
				default: state <= lcd_off;
			endcase
		end
	end

	a_en_needs_power: assert property (@(posedge clk) disable iff (!rst_n)
		!lcd_out_on |-> !lcd.en);

	a_write_only: assert property (@(posedge clk) disable iff (!rst_n)
		lcd.rw == 1'b0);

	a_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(lcd.en || $fell(lcd.en)) |-> ($stable(lcd.data) && $stable(lcd.rs)));

endmodule

/* hex_display.sv */
`timescale 1ns/10ps

module hex_display import ir_lcd_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  ir_code_t code,
	input  logic     code_valid,
	output seg_t     seg_lo,
	output seg_t     seg_hi
);

	ir_code_t code_q;

	// patterns written active high, inverted on return
	function automatic seg_t hex_seg(input logic [3:0] nib);
		case (nib)
			4'h0:    return ~7'h3F;
			4'h1:    return ~7'h06;
			4'h2:    return ~7'h5B;
			4'h3:    return ~7'h4F;
			4'h4:    return ~7'h66;
			4'h5:    return ~7'h6D;
			4'h6:    return ~7'h7D;
			4'h7:    return ~7'h07;
			4'h8:    return ~7'h7F;
			4'h9:    return ~7'h6F;
			4'hA:    return ~7'h77;
			4'hB:    return ~7'h7C;  // lower case b
			4'hC:    return ~7'h39;
			4'hD:    return ~7'h5E;  // lower case d
			4'hE:    return ~7'h79;
			default: return ~7'h71;
		endcase
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			code_q <= '0;  // shows 00
		end else if (code_valid) begin
			code_q <= code;
		end
	end

	assign seg_lo = hex_seg(code_q[3:0]);
	assign seg_hi = hex_seg(code_q[7:4]);

endmodule

/* ir_lcd_top.sv */
`timescale 1ns/10ps

module ir_lcd_top import ir_lcd_pkg::*; #(
	parameter int unit_cycles = 28125,
	parameter int en_cycles   = 25,
	parameter int wait_cycles = 2500
) (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      irda_rxd,
	input  logic      lcd_button,
	output logic      lcd_rs,
	output logic      lcd_en,
	output logic      lcd_rw,
	output logic      lcd_out_on,
	output lcd_char_t lcd_data,
	output seg_t      seven_seg_out1,
	output seg_t      seven_seg_out2
);

	ir_code_t  code;
	logic      code_valid;
	lcd_char_t char_data;
	logic      char_valid;
	lcd_bus_t  lcd_bus;

	nec_ir_decoder #(
		.unit_cycles(unit_cycles)
	) nec_ir_decoder_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.irda_rxd  (irda_rxd),
		.code      (code),
		.code_valid(code_valid)
	);

	key_to_ascii key_to_ascii_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.code      (code),
		.code_valid(code_valid),
		.char_data (char_data),
		.char_valid(char_valid)
	);

	lcd_writer #(
		.en_cycles  (en_cycles),
		.wait_cycles(wait_cycles)
	) lcd_writer_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.power_req (lcd_button),
		.char_data (char_data),
		.char_valid(char_valid),
		.lcd       (lcd_bus),
		.lcd_out_on(lcd_out_on)
	);

	hex_display hex_display_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.code      (code),
		.code_valid(code_valid),
		.seg_lo    (seven_seg_out1),  // low nibble
		.seg_hi    (seven_seg_out2)
	);

	assign lcd_rs   = lcd_bus.rs;
	assign lcd_rw   = lcd_bus.rw;
	assign lcd_en   = lcd_bus.en;
	assign lcd_data = lcd_bus.data;

endmodule

/* tb_ir_lcd.sv */
`timescale 1ns/10ps

module tb_ir_lcd;

	localparam int unit_cycles = 16;
	localparam int en_cycles   = 4;
	localparam int wait_cycles = 2200;  // one write pair outlasts two frames
	localparam int frame_cyc   = 122 * unit_cycles;  // leader, 16 ones, 16 zeros, stop
	localparam int xfer_cyc    = en_cycles + wait_cycles + 8;
	localparam int drain_limit = frame_cyc + 5 * xfer_cyc;
	localparam int max_cycles  = 2 * (24 * (frame_cyc + 3 * xfer_cyc) + 12 * xfer_cyc);

	logic       clk;
	logic       rst_n;
	logic       irda_rxd;
	logic       lcd_button;
	logic       lcd_rs;
	logic       lcd_en;
	logic       lcd_rw;
	logic       lcd_out_on;
	logic [7:0] lcd_data;
	logic [6:0] seven_seg_out1;
	logic [6:0] seven_seg_out2;

	logic [8:0] exp_q[$];  // {rs, data} in write order
	logic [8:0] exp_item;
	logic [7:0] last_code;
	int         errors;
	int         err_mark;
	int         tests_pass;
	int         tests_fail;
	int         seed;
	int         pick;

	// g..a, active low
	logic [6:0] seg_tab [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};
	logic [7:0] key_set [13] = '{8'h00, 8'h01, 8'h02, 8'h03, 8'h04, 8'h05, 8'h06,
		8'h07, 8'h08, 8'h09, 8'h0F, 8'h13, 8'h10};

	ir_lcd_top #(
		.unit_cycles(unit_cycles),
		.en_cycles  (en_cycles),
		.wait_cycles(wait_cycles)
	) ir_lcd_top_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.irda_rxd      (irda_rxd),
		.lcd_button    (lcd_button),
		.lcd_rs        (lcd_rs),
		.lcd_en        (lcd_en),
		.lcd_rw        (lcd_rw),
		.lcd_out_on    (lcd_out_on),
		.lcd_data      (lcd_data),
		.seven_seg_out1(seven_seg_out1),
		.seven_seg_out2(seven_seg_out2)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [7:0] ascii_for(input logic [7:0] code);
		if (code <= 8'h09) return 8'h30 + code;
		if (code == 8'h0F) return 8'h41;
		if (code == 8'h13) return 8'h42;
		if (code == 8'h10) return 8'h43;
		return 8'h30;
	endfunction

	// every en fall is one transfer
	always @(negedge lcd_en) begin
		if (rst_n === 1'b1) begin
			assert (exp_q.size() > 0) else begin
				$display("unexpected LCD transfer rs=%h data=%h", lcd_rs, lcd_data);
				errors++;
			end
			if (exp_q.size() > 0) begin
				exp_item = exp_q.pop_front();
				assert (lcd_rs == exp_item[8]) else begin
					$display("MISMATCH lcd_rs: got %h expected %h", lcd_rs, exp_item[8]);
					errors++;
				end
				assert (lcd_data == exp_item[7:0]) else begin
					$display("MISMATCH lcd_data: got %h expected %h", lcd_data, exp_item[7:0]);
					errors++;
				end
			end
		end
	end

	a_rw_low: assert property (@(posedge clk) disable iff (!rst_n) lcd_rw == 1'b0)
		else begin
			$display("MISMATCH lcd_rw: got %h expected 0", lcd_rw);
			errors++;
		end

	a_en_unpowered: assert property (@(posedge clk) disable iff (!rst_n)
		!lcd_out_on |-> !lcd_en)
		else begin
			$display("enable pulse seen while the LCD is unpowered");
			errors++;
		end

	task automatic tick(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic drive_line(input logic level, input int units);
		irda_rxd = level;
		tick(units * unit_cycles);
	endtask

	// nbits below 32 gives a truncated frame without stop mark
	task automatic send_frame(input logic [7:0] addr, input logic [7:0] cmd,
		input logic corrupt, input int nbits);
		logic [31:0] word;
		word = {~cmd ^ {7'd0, corrupt}, cmd, ~addr, addr};
		drive_line(1'b0, 16);
		drive_line(1'b1, 8);
		for (int i = 0; i < nbits; i++) begin
			drive_line(1'b0, 1);
			drive_line(1'b1, word[i] ? 3 : 1);
		end
		if (nbits == 32) drive_line(1'b0, 1);
		drive_line(1'b1, 1);
	endtask

	task automatic send_repeat();
		drive_line(1'b0, 16);
		drive_line(1'b1, 4);
		drive_line(1'b0, 1);
		drive_line(1'b1, 1);
	endtask

	task automatic check_display(input logic [7:0] code);
		assert (seven_seg_out1 == seg_tab[code[3:0]]) else begin
			$display("MISMATCH seven_seg_out1: got %h expected %h",
				seven_seg_out1, seg_tab[code[3:0]]);
			errors++;
		end
		assert (seven_seg_out2 == seg_tab[code[7:4]]) else begin
			$display("MISMATCH seven_seg_out2: got %h expected %h",
				seven_seg_out2, seg_tab[code[7:4]]);
			errors++;
		end
	endtask

	task automatic wait_drain(input int limit);
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < limit) begin
			@(negedge clk);
			n++;
		end
		assert (exp_q.size() == 0) else begin
			$display("missing LCD transfers, %0d still expected", exp_q.size());
			errors++;
			exp_q.delete();
		end
	endtask

	task automatic expect_init();
		exp_q.push_back({1'b0, 8'h38});
		exp_q.push_back({1'b0, 8'h0C});
		exp_q.push_back({1'b0, 8'h01});
		exp_q.push_back({1'b0, 8'h06});
	endtask

	task automatic press_key(input logic [7:0] cmd);
		exp_q.push_back({1'b0, 8'h80});
		exp_q.push_back({1'b1, ascii_for(cmd)});
		send_frame(8'h00, cmd, 1'b0, 32);
		check_display(cmd);
		last_code = cmd;
		wait_drain(drain_limit);
	endtask

	task automatic finish_test(input string name);
		if (errors == err_mark) begin
			tests_pass++;
			$display("test %s: pass", name);
		end else begin
			tests_fail++;
			$display("test %s: fail with %0d errors", name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	initial begin
		int cycles;
		cycles = 0;
		while (cycles < max_cycles) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout, run did not end within %0d cycles", max_cycles);
		$display("Test FAILED");
		$finish;
	end

	initial begin
		int n;
		rst_n      = 1'b0;
		irda_rxd   = 1'b1;
		lcd_button = 1'b0;
		errors     = 0;
		err_mark   = 0;
		tests_pass = 0;
		tests_fail = 0;
		last_code  = 8'h00;
		seed       = 32'h4b98_c63f;
		tick(5);
		rst_n = 1'b1;
		tick(2);

		// reset state, then power up
		assert (lcd_en == 1'b0 && lcd_rw == 1'b0 && lcd_out_on == 1'b0) else begin
			$display("LCD pins not idle after reset");
			errors++;
		end
		check_display(8'h00);
		tick(64);  // button low, no transfer allowed
		expect_init();
		lcd_button = 1'b1;
		n = 0;
		while (!lcd_out_on && n < 8) begin
			@(negedge clk);
			n++;
		end
		assert (lcd_out_on) else begin
			$display("lcd_out_on did not follow the button");
			errors++;
		end
		wait_drain(drain_limit);
		finish_test("reset_power");

		press_key(8'h05);
		finish_test("digit_key");

		press_key(8'h0F);
		press_key(8'h13);
		press_key(8'h10);
		press_key(8'h22);
		finish_test("letters_default");

		send_frame(8'h00, 8'h09, 1'b1, 32);  // bad cmd_n
		send_frame(8'h00, 8'h07, 1'b0, 10);
		tick(8 * unit_cycles);  // decoder times out back to idle
		send_repeat();
		tick(2 * xfer_cyc);
		check_display(last_code);
		finish_test("rejection");

		// second key lands while the first pair is written, third overwrites it
		tick(wait_cycles + 16);
		exp_q.push_back({1'b0, 8'h80});
		exp_q.push_back({1'b1, 8'h31});
		exp_q.push_back({1'b0, 8'h80});
		exp_q.push_back({1'b1, 8'h33});
		send_frame(8'h00, 8'h01, 1'b0, 32);
		send_frame(8'h00, 8'h02, 1'b0, 32);
		send_frame(8'h00, 8'h03, 1'b0, 32);
		check_display(8'h03);
		wait_drain(drain_limit);
		tick(wait_cycles + 16);
		exp_q.push_back({1'b0, 8'h80});  // char transfer is cut by power loss
		send_frame(8'h00, 8'h07, 1'b0, 32);
		check_display(8'h07);
		last_code = 8'h07;
		wait_drain(drain_limit);
		lcd_button = 1'b0;
		tick(2 * xfer_cyc);
		assert (!lcd_out_on) else begin
			$display("lcd_out_on stayed high after the button fell");
			errors++;
		end
		expect_init();
		lcd_button = 1'b1;
		wait_drain(drain_limit);
		finish_test("latest_wins_power");

		for (int i = 0; i < 12; i++) begin
			pick = $unsigned($random(seed)) % 13;
			press_key(key_set[pick]);
		end
		finish_test("random_keys");

		$display("tests passed %0d, failed %0d, errors %0d", tests_pass, tests_fail, errors);
		if (errors == 0 && tests_fail == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* verilog.f */
ir_lcd_pkg.sv
nec_ir_decoder.sv
key_to_ascii.sv
lcd_writer.sv
hex_display.sv
ir_lcd_top.sv
tb_ir_lcd.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the IR to LCD testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_ir_lcd \
	-f verilog.f -o tb_ir_lcd_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_ir_lcd_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test FAILED" "$log"; then
	exit 1
fi
if ! grep -q "Test OK" "$log"; then
	echo "no result line found in $log"
	exit 1
fi
exit 0
